//--- rtl/memscope_pkg.sv
/*
 * Shared widths, register map and control types of the capture scope
 * The register port is one word wide with a two-bit word address
 * The state code sits in bits 30:28 of the control word (see the regs)
 */
package memscope_pkg;

	// Holdoff counter and register data widths
	localparam int HOLDOFF_W = 20;
	localparam int REG_DATA_W = 32;

	// Register word addresses
	typedef enum logic [1:0]
	{
		REG_CTRL = 2'd0,
		REG_WPTR = 2'd1,
		REG_UNUSED = 2'd2
	} reg_addr_e;

	// Control word bits
	localparam int CTRL_RESET_BIT = 31;
	localparam int CTRL_MANUAL_BIT = 27;
	localparam int CTRL_DISABLE_BIT = 26;

	// Status code, read back in the control word
	typedef enum logic [2:0]
	{
		ST_UNPRIMED = 3'd0,
		ST_PRIMED = 3'd1,
		ST_TRIGGERED = 3'd2,
		ST_DONE = 3'd3,
		ST_BUS_ERR = 3'd5
	} scope_state_e;

	// Control fields handed from the regs to capture and writer
	typedef struct packed
	{
		logic [HOLDOFF_W-1:0] holdoff;
		logic manual_trigger;
		logic disable_trigger;
		logic scope_reset;
	} scope_ctrl_t;

	// Write response bit that flags SLVERR or DECERR
	localparam int BRESP_ERR_BIT = 1;

endpackage

//--- rtl/scope_beat_if.sv
/*
 * Beat channel between the capture stage and the sample FIFO
 * The source may only send while it holds a credit
 * The sink returns one credit for every beat it pops
 */
interface scope_beat_if #(
	parameter int DATA_W = 32
);
	// One captured sample per cycle at most
	logic beat_valid;
	logic [DATA_W-1:0] beat_data;
	// Last sample of the capture window
	logic beat_final;
	// Pulses once per beat leaving the FIFO
	logic beat_credit;

	modport src
	(
		output beat_valid,
		output beat_data,
		output beat_final,
		input beat_credit
	);

	modport snk
	(
		input beat_valid,
		input beat_data,
		input beat_final,
		output beat_credit
	);

endinterface

//--- rtl/scope_ctrl_regs.sv
/*
 * Single-cycle register port of the capture scope
 * Reads return data one cycle after i_reg_rd; reads are single pulses
 * A control write with bit 31 clear starts a scope reset and loads the holdoff
 * Scope reset is held at least two cycles and until the writer is idle
 */
module scope_ctrl_regs #(
	parameter int LG_MEM_WORDS = 6,
	parameter logic [memscope_pkg::HOLDOFF_W-1:0] DEF_HOLDOFF = '0
) (
	input logic i_clk,
	input logic i_reset,
	input logic i_reg_wr,
	input logic i_reg_rd,
	input memscope_pkg::reg_addr_e i_reg_addr,
	input logic [memscope_pkg::REG_DATA_W-1:0] i_reg_wdata,
	output logic [memscope_pkg::REG_DATA_W-1:0] o_reg_rdata,
	output logic o_reg_rvalid,
	output memscope_pkg::scope_ctrl_t o_ctrl,
	input logic i_primed,
	input logic i_triggered,
	input logic i_stopped,
	input logic i_busy,
	input logic i_err,
	input logic [LG_MEM_WORDS-1:0] i_wptr
);
	// State code position in the control word
	localparam int STATE_LSB = 28;

	memscope_pkg::scope_ctrl_t ctrl_q;
	memscope_pkg::scope_state_e state;
	logic [memscope_pkg::REG_DATA_W-1:0] ctrl_word;
	logic ctrl_wr;
	// Scope reset was already high last cycle
	logic reset_held;

	assign o_ctrl = ctrl_q;
	assign ctrl_wr = i_reg_wr && (i_reg_addr == memscope_pkg::REG_CTRL);

	////////////////////////////////////////
	// Control fields
	////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			ctrl_q.holdoff <= DEF_HOLDOFF;
			ctrl_q.manual_trigger <= 1'b0;
			ctrl_q.disable_trigger <= 1'b0;
			ctrl_q.scope_reset <= 1'b0;
			reset_held <= 1'b0;
		end
		else
		begin
			reset_held <= ctrl_q.scope_reset;
			// A beat may still be in the capture pipeline on the first cycle
			if (ctrl_q.scope_reset && reset_held && !i_busy)
				ctrl_q.scope_reset <= 1'b0;
			if (ctrl_wr)
			begin
				ctrl_q.manual_trigger <= i_reg_wdata[memscope_pkg::CTRL_MANUAL_BIT];
				ctrl_q.disable_trigger <= i_reg_wdata[memscope_pkg::CTRL_DISABLE_BIT];
				// Bit 31 set leaves the capture running
				if (!i_reg_wdata[memscope_pkg::CTRL_RESET_BIT])
				begin
					ctrl_q.scope_reset <= 1'b1;
					ctrl_q.holdoff <= i_reg_wdata[memscope_pkg::HOLDOFF_W-1:0];
				end
			end
		end
	end

	////////////////////////////////////////
	// Status and read data
	////////////////////////////////////////

	// Error wins over everything, then done, triggered, primed
	always_comb
	begin
		if (i_err)
			state = memscope_pkg::ST_BUS_ERR;
		else if (i_stopped && !i_busy)
			state = memscope_pkg::ST_DONE;
		else if (i_triggered)
			state = memscope_pkg::ST_TRIGGERED;
		else if (i_primed)
			state = memscope_pkg::ST_PRIMED;
		else
			state = memscope_pkg::ST_UNPRIMED;
	end

	always_comb
	begin
		ctrl_word = '0;
		ctrl_word[memscope_pkg::HOLDOFF_W-1:0] = ctrl_q.holdoff;
		ctrl_word[memscope_pkg::CTRL_DISABLE_BIT] = ctrl_q.disable_trigger;
		ctrl_word[memscope_pkg::CTRL_MANUAL_BIT] = ctrl_q.manual_trigger;
		ctrl_word[STATE_LSB+:3] = state;
		ctrl_word[memscope_pkg::CTRL_RESET_BIT] = ctrl_q.scope_reset;
	end

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			o_reg_rvalid <= 1'b0;
		else
			o_reg_rvalid <= i_reg_rd;
	end

	always_ff @(posedge i_clk)
	begin
		case (i_reg_addr)
			memscope_pkg::REG_CTRL: o_reg_rdata <= ctrl_word;
			// Next ring word to write, the oldest sample once done
			memscope_pkg::REG_WPTR: o_reg_rdata <= memscope_pkg::REG_DATA_W'(i_wptr);
			default: o_reg_rdata <= '0;
		endcase
	end

	// Reads are issued as single-cycle requests
	a_rvalid_pulse: assert property (@(posedge i_clk) disable iff (i_reset)
		o_reg_rvalid |=> !o_reg_rvalid);

endmodule

//--- rtl/scope_trigger_capture.sv
/*
 * Stream acceptance, priming, trigger and holdoff counting
 * Primed after one full ring of samples; triggers only once primed
 * The trigger sample plus holdoff more samples are captured
 * o_tready is low while in scope reset, after the last sample, or out of credits
 */
module scope_trigger_capture #(
	parameter int DATA_W = 32,
	parameter int LG_MEM_WORDS = 6,
	parameter int LG_FIFO = 4
) (
	input logic i_clk,
	input logic i_reset,
	input logic i_tvalid,
	input logic [DATA_W-1:0] i_tdata,
	output logic o_tready,
	input logic i_trigger,
	input memscope_pkg::scope_ctrl_t i_ctrl,
	scope_beat_if.src beat,
	output logic o_primed,
	output logic o_triggered,
	output logic o_stopped
);
	localparam int CW = LG_FIFO + 1;

	// Free FIFO entries as seen from this side
	logic [CW-1:0] credits;
	logic [LG_MEM_WORDS-1:0] prime_cnt;
	logic [memscope_pkg::HOLDOFF_W-1:0] remaining;
	// Trigger sample already taken, holdoff running
	logic counting;
	// Last sample accepted, no more may enter
	logic taken_all;
	logic accept;
	logic fire;
	logic trig_now;
	logic is_last;

	assign o_tready = !i_ctrl.scope_reset && !taken_all && (credits != '0);
	assign accept = i_tvalid && o_tready;

	// External trigger unless disabled, or the manual bit
	assign fire = o_primed
		&& (i_ctrl.manual_trigger || (i_trigger && !i_ctrl.disable_trigger));
	assign trig_now = o_triggered || fire;
	assign is_last = accept && trig_now
		&& (counting ? (remaining == 1) : (i_ctrl.holdoff == '0));

	////////////////////////////////////////
	// Credits
	////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			credits <= CW'(1 << LG_FIFO);
		else
		begin
			case ({accept, beat.beat_credit})
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
		end
	end

	////////////////////////////////////////
	// Priming, trigger and holdoff
	////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_reset || i_ctrl.scope_reset)
		begin
			prime_cnt <= '0;
			o_primed <= 1'b0;
			o_triggered <= 1'b0;
			counting <= 1'b0;
			taken_all <= 1'b0;
			o_stopped <= 1'b0;
		end
		else
		begin
			// One full ring of samples before a trigger counts
			if (accept && !o_primed)
			begin
				prime_cnt <= prime_cnt + 1'b1;
				if (&prime_cnt)
					o_primed <= 1'b1;
			end
			if (fire)
				o_triggered <= 1'b1;
			if (accept && trig_now)
				counting <= 1'b1;
			if (is_last)
				taken_all <= 1'b1;
			// Final beat is in the FIFO from the next cycle on
			if (beat.beat_valid && beat.beat_final)
				o_stopped <= 1'b1;
		end
	end

	always_ff @(posedge i_clk)
	begin
		if (accept && trig_now)
		begin
			if (counting)
				remaining <= remaining - 1'b1;
			else
				remaining <= i_ctrl.holdoff;
		end
	end

	////////////////////////////////////////
	// Beat out, one cycle after acceptance
	////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			beat.beat_valid <= 1'b0;
			beat.beat_final <= 1'b0;
		end
		else
		begin
			beat.beat_valid <= accept;
			beat.beat_final <= is_last;
		end
	end

	always_ff @(posedge i_clk)
	begin
		beat.beat_data <= i_tdata;
	end

	// Returned credits never outnumber the beats sent
	a_credit_bound: assert property (@(posedge i_clk) disable iff (i_reset)
		credits <= CW'(1 << LG_FIFO));

endmodule

//--- rtl/scope_sample_fifo.sv
/*
 * Beat FIFO of 2^LG_FIFO entries between capture and the burst writer
 * Head data is visible the cycle after a beat is written
 * Returns one credit per pop; never overflows as long as the source obeys credits
 */
module scope_sample_fifo #(
	parameter int DATA_W = 32,
	parameter int LG_FIFO = 4
) (
	input logic i_clk,
	input logic i_reset,
	input logic i_clear,
	scope_beat_if.snk beat,
	output logic [LG_FIFO:0] o_level,
	output logic [DATA_W-1:0] o_data,
	input logic i_pop
);
	logic [DATA_W-1:0] mem [2**LG_FIFO];
	logic [LG_FIFO-1:0] wr_ptr;
	logic [LG_FIFO-1:0] rd_ptr;
	logic [LG_FIFO:0] level;
	logic realign;

	// Drained during scope reset, so pointers restart at zero
	assign realign = i_clear && (level == '0) && !beat.beat_valid;

	always_ff @(posedge i_clk)
	begin
		if (beat.beat_valid)
			mem[wr_ptr] <= beat.beat_data;
	end

	always_ff @(posedge i_clk)
	begin
		if (i_reset || realign)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else
		begin
			if (beat.beat_valid)
				wr_ptr <= wr_ptr + 1'b1;
			if (i_pop)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			level <= '0;
		else
		begin
			case ({beat.beat_valid, i_pop})
				2'b10: level <= level + 1'b1;
				2'b01: level <= level - 1'b1;
				default: level <= level;
			endcase
		end
	end

	// Credit back to capture, one per popped beat
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			beat.beat_credit <= 1'b0;
		else
			beat.beat_credit <= i_pop;
	end

	assign o_level = level;
	assign o_data = mem[rd_ptr];

	a_no_underflow: assert property (@(posedge i_clk) disable iff (i_reset)
		i_pop |-> (level != '0));

endmodule

//--- rtl/scope_burst_writer.sv
/*
 * Writes FIFO beats into the memory ring in bursts of up to 2^LG_MAX_BURST
 * Each burst stays inside one aligned block, so it never wraps the ring
 * AW and the first W beat are raised together; B is always accepted
 * During scope reset the FIFO is flushed to memory, then the ring restarts at 0
 */
module scope_burst_writer #(
	parameter int DATA_W = 32,
	parameter int LG_MEM_WORDS = 6,
	parameter int LG_FIFO = 4,
	parameter int LG_MAX_BURST = 3
) (
	input logic i_clk,
	input logic i_reset,
	input memscope_pkg::scope_ctrl_t i_ctrl,
	input logic i_stopped,
	input logic [LG_FIFO:0] i_level,
	input logic [DATA_W-1:0] i_data,
	output logic o_pop,
	output logic o_awvalid,
	input logic i_awready,
	output logic [LG_MEM_WORDS-1:0] o_awaddr,
	output logic [7:0] o_awlen,
	output logic o_wvalid,
	input logic i_wready,
	output logic [DATA_W-1:0] o_wdata,
	output logic o_wlast,
	input logic i_bvalid,
	input logic [1:0] i_bresp,
	output logic o_busy,
	output logic o_err,
	output logic [LG_MEM_WORDS-1:0] o_wptr,
	output logic o_int
);
	localparam int BURST = 1 << LG_MAX_BURST;
	localparam int BW = LG_MAX_BURST + 1;
	localparam int LW = LG_FIFO + 1;
	// Room for every block of the ring plus slack
	localparam int OUT_W = LG_MEM_WORDS - LG_MAX_BURST + 2;

	// Next ring word to be written
	logic [LG_MEM_WORDS-1:0] wr_addr;
	// W beats still owed for the current burst
	logic [BW-1:0] w_pending;
	// Beats already sent in the current burst
	logic [7:0] w_beat;
	// Bursts issued whose B has not come back
	logic [OUT_W-1:0] out_cnt;
	logic [BW-1:0] room;
	logic [BW-1:0] len;
	logic [LW-1:0] avail;
	logic have_data;
	logic w_free;
	logic start;
	logic ring_restart;
	logic last_resp;

	////////////////////////////////////////
	// Burst sizing and start
	////////////////////////////////////////

	always_comb
	begin
		// Words left in the current aligned block
		room = BW'(BURST) - BW'(wr_addr[LG_MAX_BURST-1:0]);
		// Beats in the FIFO not yet claimed by a burst
		avail = i_level - LW'(w_pending);
		if (avail >= LW'(room))
			len = room;
		else
			len = avail[BW-1:0];
		// Partial bursts only once no more beats are coming
		have_data = (avail >= LW'(room))
			|| ((i_stopped || i_ctrl.scope_reset) && (avail != '0));
		// Current burst ends this cycle or none is running
		w_free = (w_pending == '0) || ((w_pending == 1) && i_wready);
		start = have_data && w_free && (!o_awvalid || i_awready) && (out_cnt != '1);
	end

	assign ring_restart = i_ctrl.scope_reset && !o_busy;

	always_ff @(posedge i_clk)
	begin
		if (i_reset || ring_restart)
			wr_addr <= '0;
		else if (start)
			wr_addr <= wr_addr + LG_MEM_WORDS'(len);
	end

	////////////////////////////////////////
	// AW and W channels
	////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			o_awvalid <= 1'b0;
		else if (start)
			o_awvalid <= 1'b1;
		else if (i_awready)
			o_awvalid <= 1'b0;
	end

	always_ff @(posedge i_clk)
	begin
		if (start)
		begin
			o_awaddr <= wr_addr;
			o_awlen <= 8'(len) - 8'd1;
		end
	end

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			w_pending <= '0;
		else if (start)
			w_pending <= len;
		else if (o_pop)
			w_pending <= w_pending - 1'b1;
	end

	always_ff @(posedge i_clk)
	begin
		if (i_reset || start)
			w_beat <= '0;
		else if (o_pop)
			w_beat <= w_beat + 1'b1;
	end

	assign o_wvalid = (w_pending != '0);
	assign o_wlast = (w_pending == 1);
	assign o_wdata = i_data;
	assign o_pop = o_wvalid && i_wready;

	////////////////////////////////////////
	// Responses, error and completion
	////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			out_cnt <= '0;
		else
		begin
			case ({start, i_bvalid})
				2'b10: out_cnt <= out_cnt + 1'b1;
				2'b01: out_cnt <= out_cnt - 1'b1;
				default: out_cnt <= out_cnt;
			endcase
		end
	end

	assign o_busy = o_awvalid || (w_pending != '0) || (out_cnt != '0) || (i_level != '0);

	// Sticky until the next scope reset completes
	always_ff @(posedge i_clk)
	begin
		if (i_reset || ring_restart)
			o_err <= 1'b0;
		else if (i_bvalid && i_bresp[memscope_pkg::BRESP_ERR_BIT])
			o_err <= 1'b1;
	end

	// Last response of a stopped capture with nothing left behind it
	assign last_resp = i_bvalid && (out_cnt == 1) && !o_awvalid
		&& (w_pending == '0) && (i_level == '0) && i_stopped;

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			o_int <= 1'b0;
		else
			o_int <= last_resp;
	end

	assign o_wptr = wr_addr;

	// A burst ends on the beat that matches its AW length
	a_wlast_end: assert property (@(posedge i_clk) disable iff (i_reset)
		o_wvalid |-> (o_wlast == (w_beat == o_awlen)));

	// Burst stays within its aligned block
	a_aw_block: assert property (@(posedge i_clk) disable iff (i_reset)
		o_awvalid |-> ((int'(o_awaddr[LG_MAX_BURST-1:0]) + int'(o_awlen)) < BURST));

endmodule

//--- rtl/memscope_top.sv
/*
 * Memory-backed capture scope, top level
 * Word addresses on AW; ID, size, burst type, cache and strobes are constants
 * left to the interconnect. B responses are always accepted
 * LG_MAX_BURST must be below LG_FIFO and at most LG_MEM_WORDS
 */
module memscope_top #(
	parameter int DATA_W = 32,
	parameter int LG_MEM_WORDS = 6,
	parameter int LG_FIFO = 4,
	parameter int LG_MAX_BURST = 3,
	parameter logic [memscope_pkg::HOLDOFF_W-1:0] DEF_HOLDOFF = '0
) (
	input logic i_clk,
	input logic i_reset,
	// Sample stream
	input logic i_tvalid,
	input logic [DATA_W-1:0] i_tdata,
	output logic o_tready,
	input logic i_trigger,
	// Register port
	input logic i_reg_wr,
	input logic i_reg_rd,
	input memscope_pkg::reg_addr_e i_reg_addr,
	input logic [memscope_pkg::REG_DATA_W-1:0] i_reg_wdata,
	output logic [memscope_pkg::REG_DATA_W-1:0] o_reg_rdata,
	output logic o_reg_rvalid,
	// Memory write channels
	output logic o_awvalid,
	input logic i_awready,
	output logic [LG_MEM_WORDS-1:0] o_awaddr,
	output logic [7:0] o_awlen,
	output logic o_wvalid,
	input logic i_wready,
	output logic [DATA_W-1:0] o_wdata,
	output logic o_wlast,
	input logic i_bvalid,
	input logic [1:0] i_bresp,
	// Capture complete
	output logic o_int
);
	memscope_pkg::scope_ctrl_t ctrl;
	logic primed;
	logic triggered;
	logic stopped;
	logic busy;
	logic err;
	logic [LG_MEM_WORDS-1:0] wptr;
	logic [LG_FIFO:0] fifo_level;
	logic [DATA_W-1:0] fifo_data;
	logic fifo_pop;

	scope_beat_if #(.DATA_W(DATA_W)) beat ();

	scope_ctrl_regs #(
		.LG_MEM_WORDS(LG_MEM_WORDS),
		.DEF_HOLDOFF(DEF_HOLDOFF)
	) u_regs (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_reg_wr(i_reg_wr), .i_reg_rd(i_reg_rd), .i_reg_addr(i_reg_addr),
		.i_reg_wdata(i_reg_wdata), .o_reg_rdata(o_reg_rdata), .o_reg_rvalid(o_reg_rvalid),
		.o_ctrl(ctrl), .i_primed(primed), .i_triggered(triggered),
		.i_stopped(stopped), .i_busy(busy), .i_err(err), .i_wptr(wptr)
	);

	scope_trigger_capture #(
		.DATA_W(DATA_W),
		.LG_MEM_WORDS(LG_MEM_WORDS),
		.LG_FIFO(LG_FIFO)
	) u_capture (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_tvalid(i_tvalid), .i_tdata(i_tdata), .o_tready(o_tready),
		.i_trigger(i_trigger), .i_ctrl(ctrl), .beat(beat.src),
		.o_primed(primed), .o_triggered(triggered), .o_stopped(stopped)
	);

	scope_sample_fifo #(
		.DATA_W(DATA_W),
		.LG_FIFO(LG_FIFO)
	) u_fifo (
		.i_clk(i_clk), .i_reset(i_reset), .i_clear(ctrl.scope_reset),
		.beat(beat.snk), .o_level(fifo_level), .o_data(fifo_data), .i_pop(fifo_pop)
	);

	scope_burst_writer #(
		.DATA_W(DATA_W),
		.LG_MEM_WORDS(LG_MEM_WORDS),
		.LG_FIFO(LG_FIFO),
		.LG_MAX_BURST(LG_MAX_BURST)
	) u_writer (
		.i_clk(i_clk), .i_reset(i_reset), .i_ctrl(ctrl), .i_stopped(stopped),
		.i_level(fifo_level), .i_data(fifo_data), .o_pop(fifo_pop),
		.o_awvalid(o_awvalid), .i_awready(i_awready), .o_awaddr(o_awaddr),
		.o_awlen(o_awlen), .o_wvalid(o_wvalid), .i_wready(i_wready),
		.o_wdata(o_wdata), .o_wlast(o_wlast), .i_bvalid(i_bvalid), .i_bresp(i_bresp),
		.o_busy(busy), .o_err(err), .o_wptr(wptr), .o_int(o_int)
	);

endmodule

//--- sim/tb_clock_gen.sv
/*
 * Free-running clock and a synchronous active-high reset
 * Reset is released on a rising edge after RESET_CYCLES edges
 */
module tb_clock_gen #(
	parameter int PERIOD = 100,
	parameter int RESET_CYCLES = 4
) (
	output logic o_clk,
	output logic o_reset
);
	initial
	begin
		o_clk = 1'b0;
		forever #(PERIOD / 2) o_clk = ~o_clk;
	end

	initial
	begin
		o_reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge o_clk);
		o_reset <= 1'b0;
	end

endmodule

//--- sim/memscope_tb.sv
/*
 * Table-driven regression of the capture scope
 * Ring of 64 words, 16-entry FIFO, bursts of up to 8 words
 * Every trigger index must lie past the priming window (k >= 72 here)
 * The memory model answers bursts in order, one B per cycle at most
 */
module memscope_tb;
	localparam int DATA_W = 32;
	localparam int RING = 64;
	localparam int NROWS = 6;

	////////////////////////////////////////
	// Test table
	////////////////////////////////////////

	// Holdoff, trigger sample, manual source, disable, error burst, stalls, end state
	localparam int ROW_HOLD [NROWS] = '{0, 40, 13, 20, 30, 5};
	localparam int ROW_TRIG [NROWS] = '{72, 80, 75, 90, 72, 100};
	localparam bit ROW_MANUAL [NROWS] = '{1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0};
	localparam bit ROW_DIS [NROWS] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
	localparam int ROW_ERR [NROWS] = '{-1, -1, -1, -1, 10, -1};
	localparam bit ROW_STALL [NROWS] = '{1'b0, 1'b1, 1'b0, 1'b1, 1'b1, 1'b1};
	localparam memscope_pkg::scope_state_e ROW_EXP [NROWS] = '{
		memscope_pkg::ST_DONE, memscope_pkg::ST_DONE, memscope_pkg::ST_DONE,
		memscope_pkg::ST_DONE, memscope_pkg::ST_BUS_ERR, memscope_pkg::ST_DONE};

	// Samples captured over all rows
	function automatic int window_total();
		int sum;
		sum = 0;
		for (int r = 0; r < NROWS; r++)
			sum += ROW_TRIG[r] + ROW_HOLD[r];
		return sum;
	endfunction

	localparam int CYCLE_LIMIT = window_total() * 20 + 2000;

	logic clk;
	logic reset;
	logic tvalid = 1'b0;
	logic [DATA_W-1:0] tdata = '0;
	logic tready;
	logic trigger = 1'b0;
	logic reg_wr = 1'b0;
	logic reg_rd = 1'b0;
	memscope_pkg::reg_addr_e reg_addr = memscope_pkg::REG_CTRL;
	logic [memscope_pkg::REG_DATA_W-1:0] reg_wdata = '0;
	logic [memscope_pkg::REG_DATA_W-1:0] reg_rdata;
	logic reg_rvalid;
	logic awvalid;
	logic awready = 1'b0;
	logic [5:0] awaddr;
	logic [7:0] awlen;
	logic wvalid;
	logic wready = 1'b0;
	logic [DATA_W-1:0] wdata;
	logic wlast;
	logic bvalid = 1'b0;
	logic [1:0] bresp = 2'b00;
	logic irq;

	// Memory model state
	logic [DATA_W-1:0] ring_mem [RING];
	int aw_addr_q[$];
	int aw_len_q[$];
	int aw_id_q[$];
	int b_id_q[$];
	int beat_idx = 0;
	int burst_count = 0;
	int burst_base = 0;
	int err_burst_cur = -1;
	bit stall_cur = 1'b0;
	bit clear_mem = 1'b0;
	integer seed = 32'h7919d97c;

	int int_count = 0;
	int cycles = 0;
	int error_count = 0;

	tb_clock_gen #(.PERIOD(100), .RESET_CYCLES(4)) u_clk (.o_clk(clk), .o_reset(reset));

	memscope_top #(
		.DATA_W(DATA_W),
		.LG_MEM_WORDS(6),
		.LG_FIFO(4),
		.LG_MAX_BURST(3),
		.DEF_HOLDOFF('0)
	) dut0 (
		.i_clk(clk), .i_reset(reset),
		.i_tvalid(tvalid), .i_tdata(tdata), .o_tready(tready), .i_trigger(trigger),
		.i_reg_wr(reg_wr), .i_reg_rd(reg_rd), .i_reg_addr(reg_addr),
		.i_reg_wdata(reg_wdata), .o_reg_rdata(reg_rdata), .o_reg_rvalid(reg_rvalid),
		.o_awvalid(awvalid), .i_awready(awready), .o_awaddr(awaddr), .o_awlen(awlen),
		.o_wvalid(wvalid), .i_wready(wready), .o_wdata(wdata), .o_wlast(wlast),
		.i_bvalid(bvalid), .i_bresp(bresp), .o_int(irq)
	);

	////////////////////////////////////////
	// Failure reporting and compares
	////////////////////////////////////////

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("Regression failed");
		$fatal(1, "stopped at first failure");
	endtask

	task automatic check_state(input string name, input memscope_pkg::scope_state_e exp,
		input memscope_pkg::scope_state_e act);
		if (act !== exp)
		begin
			error_count++;
			$display("** Error %s expected %0d actual %0d", name, exp, act);
			$display("Regression failed");
			$fatal(1, "state mismatch");
		end
	endtask

	task automatic check_word(input string name, input logic [memscope_pkg::REG_DATA_W-1:0] exp,
		input logic [memscope_pkg::REG_DATA_W-1:0] act);
		if (act !== exp)
		begin
			error_count++;
			$display("** Error %s expected %h actual %h", name, exp, act);
			$display("Regression failed");
			$fatal(1, "word mismatch");
		end
	endtask

	task automatic check_sample(input string name, input logic [DATA_W-1:0] exp,
		input logic [DATA_W-1:0] act);
		if (act !== exp)
		begin
			error_count++;
			$display("** Error %s expected %0d actual %0d", name, exp, act);
			$display("Regression failed");
			$fatal(1, "sample mismatch");
		end
	endtask

	// State code sits in bits 30:28 of CTRL
	function automatic memscope_pkg::scope_state_e state_of(input logic [31:0] w);
		return memscope_pkg::scope_state_e'(w[30:28]);
	endfunction

	// Last sample number that lands on ring word a after n samples from word 0
	function automatic logic [DATA_W-1:0] expected_word(input int a, input int n);
		return DATA_W'(a + 1 + RING * ((n - 1 - a) / RING));
	endfunction

	////////////////////////////////////////
	// Timeout, interrupt counter
	////////////////////////////////////////

	always @(posedge clk)
	begin
		cycles++;
		if (irq)
			int_count++;
		if (cycles > CYCLE_LIMIT)
		begin
			$display("Timeout after %0d cycles, the DUT stopped making progress", cycles);
			$display("Regression failed");
			$fatal(1, "timeout");
		end
	end

	////////////////////////////////////////
	// Memory slave model
	////////////////////////////////////////

	always @(posedge clk)
	begin
		int a;
		if (clear_mem)
		begin
			// Fill marks every word with its own address
			for (int i = 0; i < RING; i++)
				ring_mem[6'(i)] = 32'hdead0000 | DATA_W'(i);
		end
		if (reset)
		begin
			awready <= 1'b0;
			wready <= 1'b0;
			bvalid <= 1'b0;
			bresp <= 2'b00;
		end
		else
		begin
			if (awvalid && awready)
			begin
				if (int'(awaddr[2:0]) + int'(awlen) > 7)
					report_failure("Burst crosses its 8-word block");
				aw_addr_q.push_back(int'(awaddr));
				aw_len_q.push_back(int'(awlen));
				aw_id_q.push_back(burst_count);
				burst_count++;
			end
			if (wvalid && wready)
			begin
				a = (aw_addr_q[0] + beat_idx) % RING;
				ring_mem[6'(a)] = wdata;
				if (wlast !== (beat_idx == aw_len_q[0]))
					report_failure("wlast does not mark the final beat of a burst");
				if (beat_idx == aw_len_q[0])
				begin
					b_id_q.push_back(aw_id_q[0]);
					void'(aw_addr_q.pop_front());
					void'(aw_len_q.pop_front());
					void'(aw_id_q.pop_front());
					beat_idx = 0;
				end
				else
					beat_idx++;
			end
			// One response per cycle, in burst order
			if (b_id_q.size() != 0 && (!stall_cur || (($random(seed) & 1) != 0)))
			begin
				bvalid <= 1'b1;
				// SLVERR on the chosen burst of the row
				bresp <= (b_id_q[0] == burst_base + err_burst_cur) ? 2'b10 : 2'b00;
				void'(b_id_q.pop_front());
			end
			else
			begin
				bvalid <= 1'b0;
				bresp <= 2'b00;
			end
			awready <= !stall_cur || (($random(seed) & 3) != 0);
			wready <= (aw_addr_q.size() != 0) && (!stall_cur || (($random(seed) & 3) != 0));
		end
	end

	////////////////////////////////////////
	// Stream and register drivers
	////////////////////////////////////////

	task automatic reg_write(input memscope_pkg::reg_addr_e a, input logic [31:0] d);
		reg_wr <= 1'b1;
		reg_addr <= a;
		reg_wdata <= d;
		@(posedge clk);
		reg_wr <= 1'b0;
	endtask

	// Data is expected exactly one cycle after the request
	task automatic reg_read(input memscope_pkg::reg_addr_e a, output logic [31:0] d);
		reg_rd <= 1'b1;
		reg_addr <= a;
		@(posedge clk);
		reg_rd <= 1'b0;
		@(posedge clk);
		if (!reg_rvalid)
			report_failure("Register read gave no response one cycle later");
		d = reg_rdata;
	endtask

	// Holds the sample until the DUT takes it
	task automatic send_sample(input int value, input logic trig);
		tvalid <= 1'b1;
		tdata <= DATA_W'(value);
		trigger <= trig;
		do
			@(posedge clk);
		while (!tready);
	endtask

	task automatic stop_stream();
		tvalid <= 1'b0;
		trigger <= 1'b0;
	endtask

	task automatic run_row(input int r);
		int k;
		int h;
		int n;
		int ints_start;
		logic trig;
		logic [31:0] word;
		logic [31:0] ctrl;
		memscope_pkg::scope_state_e mid;
		k = ROW_TRIG[r];
		h = ROW_HOLD[r];
		n = k + h;
		err_burst_cur = ROW_ERR[r];
		stall_cur = ROW_STALL[r];
		burst_base = burst_count;
		ints_start = int_count;
		clear_mem <= 1'b1;
		@(posedge clk);
		clear_mem <= 1'b0;

		// Scope reset with new holdoff, then wait for it to finish
		ctrl = '0;
		ctrl[memscope_pkg::HOLDOFF_W-1:0] = memscope_pkg::HOLDOFF_W'(h);
		ctrl[memscope_pkg::CTRL_DISABLE_BIT] = ROW_DIS[r];
		reg_write(memscope_pkg::REG_CTRL, ctrl);
		do
			reg_read(memscope_pkg::REG_CTRL, word);
		while (word[memscope_pkg::CTRL_RESET_BIT]);
		check_word($sformatf("row%0d holdoff", r), h, 32'(word[19:0]));
		check_state($sformatf("row%0d after scope reset", r), memscope_pkg::ST_UNPRIMED,
			state_of(word));

		for (int s = 1; s <= n; s++)
		begin
			// Status probes at fixed points of the window
			if (s == 20 || s == k - 2 || (s == k + 5 && h >= 10))
			begin
				stop_stream();
				reg_read(memscope_pkg::REG_CTRL, word);
				if (s == 20)
					mid = memscope_pkg::ST_UNPRIMED;
				else if (s == k - 2)
					mid = memscope_pkg::ST_PRIMED;
				else
					mid = memscope_pkg::ST_TRIGGERED;
				check_state($sformatf("row%0d state before sample %0d", r, s), mid,
					state_of(word));
			end
			if (ROW_MANUAL[r] && s == k)
			begin
				stop_stream();
				reg_write(memscope_pkg::REG_CTRL, ctrl | 32'h8800_0000);
			end
			// Early pulse while unprimed, and a disabled pulse, must both be ignored
			trig = (s == 10) || (!ROW_MANUAL[r] && s == k) || (ROW_DIS[r] && s == k - 6);
			send_sample(s, trig);
		end

		// No further sample may enter
		tvalid <= 1'b1;
		tdata <= DATA_W'(n + 1);
		trigger <= 1'b0;
		repeat (40)
		begin
			@(posedge clk);
			if (tready)
				report_failure("Sample accepted after the capture window closed");
		end
		stop_stream();

		while (int_count == ints_start)
			@(posedge clk);
		repeat (20) @(posedge clk);
		check_word($sformatf("row%0d interrupt pulses", r), 1, int_count - ints_start);

		reg_read(memscope_pkg::REG_CTRL, word);
		check_state($sformatf("row%0d final state", r), ROW_EXP[r], state_of(word));
		reg_read(memscope_pkg::REG_WPTR, word);
		check_word($sformatf("row%0d write pointer", r), n % RING, word);
		for (int a = 0; a < RING; a++)
			check_sample($sformatf("row%0d ring word %0d", r, a), expected_word(a, n),
				ring_mem[6'(a)]);
	endtask

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////

	initial
	begin
		logic [31:0] word;
		@(posedge clk);
		while (reset)
			@(posedge clk);
		check_word("reset awvalid", 0, 32'(awvalid));
		check_word("reset wvalid", 0, 32'(wvalid));
		check_word("reset int", 0, 32'(irq));
		check_word("reset rvalid", 0, 32'(reg_rvalid));
		reg_read(memscope_pkg::REG_CTRL, word);
		check_word("reset holdoff", 0, 32'(word[19:0]));
		check_state("reset state", memscope_pkg::ST_UNPRIMED, state_of(word));

		for (int r = 0; r < NROWS; r++)
			run_row(r);

		if (error_count == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

//--- memscope.f
rtl/memscope_pkg.sv
rtl/scope_beat_if.sv
rtl/scope_ctrl_regs.sv
rtl/scope_trigger_capture.sv
rtl/scope_sample_fifo.sv
rtl/scope_burst_writer.sv
rtl/memscope_top.sv
sim/tb_clock_gen.sv
sim/memscope_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module memscope_tb \
	-f memscope.f -o memscope_sim &&
out="$(./obj_dir/memscope_sim 2>&1)"
echo "$out"
echo "$out" | grep -qx "Regression passed" && echo "PASS" || { echo "FAIL"; exit 1; }
